// File: logic/bpPkg.sv
// ********************
// Sizes, opcodes and records shared by the branch prediction front end
// The BTB and PHT sizes must stay powers of two matching their index widths
// RV32 only; compressed instructions are not supported
// ********************

package bpPkg;

    // Datapath and fetch
    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] PC_START = 32'h0000_1000;

    // Branch target buffer geometry
    localparam int BTB_ENTRIES = 32;
    localparam int BTB_IDX_W = 5;
    // Tag covers the PC bits above the index and the byte offset
    localparam int BTB_TAG_W = XLEN - BTB_IDX_W - 2;

    // Gshare direction predictor geometry
    localparam int GHR_BITS = 3;
    localparam int PHT_ENTRIES = 1024;
    localparam int PHT_IDX_W = 10;

    // RV32I major opcodes for control transfer
    localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
    localparam logic [6:0] OPCODE_JAL = 7'b1101111;
    localparam logic [6:0] OPCODE_JALR = 7'b1100111;

    typedef enum logic [1:0] {
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_OTHER
    } opClassE;

    // BTB answer for the fetch PC
    typedef struct packed {
        logic            hit;
        logic [XLEN-1:0] target;
        logic            isJump;
    } btbLookupT;

    // Direction answer and the index it came from
    typedef struct packed {
        logic                 predictTaken;
        logic [PHT_IDX_W-1:0] index;
    } phtLookupT;

    typedef struct packed {
        logic            we;
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] target;
        logic            isJump;
    } btbWriteT;

    // Same strobe trains the counter and shifts the GHR
    typedef struct packed {
        logic                 we;
        logic [PHT_IDX_W-1:0] index;
        logic                 taken;
    } phtUpdateT;

    // One record per executed instruction
    typedef struct packed {
        logic                 valid;
        logic                 isBranch;
        logic                 isJump;
        logic                 taken;
        logic [XLEN-1:0]      pc;
        logic [XLEN-1:0]      target;
        logic [XLEN-1:0]      nextPcFetched;
        logic [PHT_IDX_W-1:0] phtIndex;
    } resolveT;

endpackage

// File: logic/targetBuffer.sv
// ********************
// Direct-mapped BTB, indexed by PC bits 6:2
// Lookup is combinational; a same-cycle write is seen one cycle later
// Only valid bits are reset; tags and targets are undefined until written
// ********************
`timescale 1ns/100ps

module targetBuffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [bpPkg::XLEN-1:0]      pcF_i,
    input  bpPkg::btbWriteT             write_i,
    output bpPkg::btbLookupT            lookup_o
);

    // Entry storage
    logic [bpPkg::BTB_ENTRIES-1:0] validQ;
    logic [bpPkg::BTB_ENTRIES-1:0] jumpQ;
    logic [bpPkg::BTB_TAG_W-1:0]   tagQ    [bpPkg::BTB_ENTRIES];
    logic [bpPkg::XLEN-1:0]        targetQ [bpPkg::BTB_ENTRIES];

    // Read side
    logic [bpPkg::BTB_IDX_W-1:0] rdIdx;
    logic [bpPkg::BTB_TAG_W-1:0] rdTag;
    logic                        tagMatch;

    // Write side
    logic [bpPkg::BTB_IDX_W-1:0] wrIdx;
    logic [bpPkg::BTB_TAG_W-1:0] wrTag;

    assign rdIdx = pcF_i[bpPkg::BTB_IDX_W+1:2];
    assign rdTag = pcF_i[bpPkg::XLEN-1:bpPkg::BTB_IDX_W+2];

    assign wrIdx = write_i.pc[bpPkg::BTB_IDX_W+1:2];
    assign wrTag = write_i.pc[bpPkg::XLEN-1:bpPkg::BTB_IDX_W+2];

    assign tagMatch = (tagQ[rdIdx] == rdTag);

    always_comb begin
        lookup_o.hit    = validQ[rdIdx] && tagMatch;
        lookup_o.target = targetQ[rdIdx];
        lookup_o.isJump = jumpQ[rdIdx];
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            validQ <= '0;
        end else if (write_i.we) begin
            validQ[wrIdx] <= 1'b1;
        end
    end

    // Payload, no reset needed behind the valid bit
    always_ff @(posedge clk) begin
        if (write_i.we) begin
            tagQ[wrIdx]    <= wrTag;
            targetQ[wrIdx] <= write_i.target;
            jumpQ[wrIdx]   <= write_i.isJump;
        end
    end

    // Targets come from the execute stage and must be word aligned,
    // otherwise fetch would follow a misaligned prediction
    aWriteTargetAligned: assert property (
        @(posedge clk) disable iff (reset)
        write_i.we |-> (write_i.target[1:0] == 2'b00)
    ) else $error("BTB write with misaligned target %h", write_i.target);

endmodule

// File: logic/directionPredictor.sv
// ********************
// Gshare predictor: 1024 two-bit counters and a 3-bit GHR
// GHR shifts only at resolution, so history is non-speculative
// Counters reset to weakly not taken (01)
// ********************
`timescale 1ns/100ps

module directionPredictor (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [bpPkg::XLEN-1:0] pcF_i,
    input  bpPkg::phtUpdateT       update_i,
    output bpPkg::phtLookupT       lookup_o
);

    logic [bpPkg::GHR_BITS-1:0]  ghrQ;
    logic [1:0]                  phtQ [bpPkg::PHT_ENTRIES];

    logic [bpPkg::PHT_IDX_W-1:0] pcBits;
    logic [bpPkg::PHT_IDX_W-1:0] foldIdx;
    logic [1:0]                  curCount;
    logic [1:0]                  nextCount;

    // PC bits 11:2 with the low history bits folded in
    assign pcBits  = pcF_i[bpPkg::PHT_IDX_W+1:2];
    assign foldIdx = pcBits ^ {{(bpPkg::PHT_IDX_W - bpPkg::GHR_BITS){1'b0}}, ghrQ};

    always_comb begin
        lookup_o.index        = foldIdx;
        lookup_o.predictTaken = phtQ[foldIdx][1];
    end

    // Saturating counter step
    assign curCount = phtQ[update_i.index];

    always_comb begin
        nextCount = curCount;
        if (update_i.taken) begin
            if (curCount != 2'b11) begin
                nextCount = curCount + 2'd1;
            end
        end else begin
            if (curCount != 2'b00) begin
                nextCount = curCount - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < bpPkg::PHT_ENTRIES; i++) begin
                phtQ[i] <= 2'b01;
            end
        end else if (update_i.we) begin
            phtQ[update_i.index] <= nextCount;
        end
    end

    // Newest outcome enters at bit 0
    always_ff @(posedge clk) begin
        if (reset) begin
            ghrQ <= '0;
        end else if (update_i.we) begin
            ghrQ <= {ghrQ[bpPkg::GHR_BITS-2:0], update_i.taken};
        end
    end

    // Index is carried down the pipe from fetch; an X here would
    // corrupt an arbitrary counter
    aUpdateIndexKnown: assert property (
        @(posedge clk) disable iff (reset)
        update_i.we |-> !$isunknown(update_i.index)
    ) else $error("PHT update with unknown index");

endmodule

// File: logic/fetchSteer.sv
// ********************
// Fetch PC register, next-PC choice and execute-time resolution
// Priority into the PC: redirect, then stall, then prediction
// Redirect and update requests are combinational from resolve_i
// ********************
`timescale 1ns/100ps

module fetchSteer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stallF_i,
    input  logic [bpPkg::XLEN-1:0]      instrF_i,
    input  bpPkg::resolveT              resolve_i,
    input  bpPkg::btbLookupT            btbLookup_i,
    input  bpPkg::phtLookupT            phtLookup_i,
    output logic [bpPkg::XLEN-1:0]      pcF_o,
    output logic [bpPkg::PHT_IDX_W-1:0] phtIndexF_o,
    output logic                        redirect_o,
    output logic [bpPkg::XLEN-1:0]      redirectPc_o,
    output bpPkg::btbWriteT             btbWrite_o,
    output bpPkg::phtUpdateT            phtUpdate_o
);

    logic [bpPkg::XLEN-1:0] pcQ;
    logic [bpPkg::XLEN-1:0] pcPlus4F;
    logic [bpPkg::XLEN-1:0] predNextPc;
    logic [bpPkg::XLEN-1:0] pcNext;
    bpPkg::opClassE         opClassF;
    logic                   isCtrlF;
    logic                   useTargetF;

    logic                   changesFlowE;
    logic [bpPkg::XLEN-1:0] actualNextPcE;

    // Opcode class of the fetched word
    always_comb begin
        case (instrF_i[6:0])
            bpPkg::OPCODE_BRANCH: opClassF = bpPkg::OP_BRANCH;
            bpPkg::OPCODE_JAL:    opClassF = bpPkg::OP_JAL;
            bpPkg::OPCODE_JALR:   opClassF = bpPkg::OP_JALR;
            default:              opClassF = bpPkg::OP_OTHER;
        endcase
    end

    assign isCtrlF = (opClassF != bpPkg::OP_OTHER);

    // Jumps always take a BTB hit, branches follow the counter
    assign useTargetF = isCtrlF && btbLookup_i.hit &&
                        (btbLookup_i.isJump || phtLookup_i.predictTaken);

    assign pcPlus4F   = pcQ + 32'd4;
    assign predNextPc = useTargetF ? btbLookup_i.target : pcPlus4F;

    // Resolution
    assign changesFlowE  = resolve_i.isJump || (resolve_i.isBranch && resolve_i.taken);
    assign actualNextPcE = changesFlowE ? resolve_i.target : resolve_i.pc + 32'd4;

    assign redirect_o   = resolve_i.valid && (actualNextPcE != resolve_i.nextPcFetched);
    assign redirectPc_o = actualNextPcE;

    // BTB learns jumps and taken branches
    always_comb begin
        btbWrite_o.we     = resolve_i.valid && changesFlowE;
        btbWrite_o.pc     = resolve_i.pc;
        btbWrite_o.target = resolve_i.target;
        btbWrite_o.isJump = resolve_i.isJump;
    end

    // Every resolved branch trains its counter and the GHR
    always_comb begin
        phtUpdate_o.we    = resolve_i.valid && resolve_i.isBranch;
        phtUpdate_o.index = resolve_i.phtIndex;
        phtUpdate_o.taken = resolve_i.taken;
    end

    // PC source, redirect wins even over a stall
    always_comb begin
        if (redirect_o) begin
            pcNext = redirectPc_o;
        end else if (stallF_i) begin
            pcNext = pcQ;
        end else begin
            pcNext = predNextPc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pcQ <= bpPkg::PC_START;
        end else begin
            pcQ <= pcNext;
        end
    end

    assign pcF_o       = pcQ;
    assign phtIndexF_o = phtLookup_i.index;

    // Holds only while redirect targets and BTB contents stay aligned
    aPcAligned: assert property (
        @(posedge clk) disable iff (reset)
        pcQ[1:0] == 2'b00
    ) else $error("Fetch PC misaligned: %h", pcQ);

endmodule

// File: logic/fetchPredictor.sv
// ********************
// Branch prediction front end for a five-stage RV32 pipeline
// One resolve record per executed instruction is expected from execute
// stallF_i is the only back-pressure
// ********************
`timescale 1ns/100ps

module fetchPredictor (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stallF_i,
    input  logic [bpPkg::XLEN-1:0]      instrF_i,
    input  bpPkg::resolveT              resolve_i,
    output logic [bpPkg::XLEN-1:0]      pcF_o,
    output logic [bpPkg::PHT_IDX_W-1:0] phtIndexF_o,
    output logic                        redirect_o,
    output logic [bpPkg::XLEN-1:0]      redirectPc_o
);

    logic [bpPkg::XLEN-1:0] pcF;
    bpPkg::btbLookupT       btbLookup;
    bpPkg::phtLookupT       phtLookup;
    bpPkg::btbWriteT        btbWrite;
    bpPkg::phtUpdateT       phtUpdate;

    // Target and direction are looked up side by side
    targetBuffer targetBuffer_i (
        .clk      (clk),
        .reset    (reset),
        .pcF_i    (pcF),
        .write_i  (btbWrite),
        .lookup_o (btbLookup)
    );

    directionPredictor directionPredictor_i (
        .clk      (clk),
        .reset    (reset),
        .pcF_i    (pcF),
        .update_i (phtUpdate),
        .lookup_o (phtLookup)
    );

    fetchSteer fetchSteer_i (
        .clk          (clk),
        .reset        (reset),
        .stallF_i     (stallF_i),
        .instrF_i     (instrF_i),
        .resolve_i    (resolve_i),
        .btbLookup_i  (btbLookup),
        .phtLookup_i  (phtLookup),
        .pcF_o        (pcF),
        .phtIndexF_o  (phtIndexF_o),
        .redirect_o   (redirect_o),
        .redirectPc_o (redirectPc_o),
        .btbWrite_o   (btbWrite),
        .phtUpdate_o  (phtUpdate)
    );

    assign pcF_o = pcF;

endmodule

// File: test/fetchPredictorTb.sv
// ********************
// Replays test/fetchGolden.txt, one line per clock cycle
// Inputs change on the falling edge and outputs are sampled 1 ns before it
// redirectPc_o is compared only on lines that expect a redirect
// phtIndexF_o is checked against a history model fed by the resolves
// ********************
`timescale 1ns/100ps

module fetchPredictorTb;

    localparam int MAX_LINES = 64;
    localparam int LINE_W = 220;
    localparam int RESET_CYCLES = 2;

    // One golden line with fields in file order
    typedef struct packed {
        logic [3:0]  test;
        logic [3:0]  stall;
        logic [31:0] instr;
        logic [3:0]  flags;
        logic [31:0] pc;
        logic [31:0] target;
        logic [31:0] nextPcFetched;
        logic [11:0] phtIndex;
        logic [31:0] expPc;
        logic [3:0]  expRedirect;
        logic [31:0] expRedirectPc;
    } goldenLineT;

    logic                        clk;
    logic                        reset;
    logic                        stallF;
    logic [bpPkg::XLEN-1:0]      instrF;
    bpPkg::resolveT              resolve;
    logic [bpPkg::XLEN-1:0]      pcF;
    logic [bpPkg::PHT_IDX_W-1:0] phtIndexF;
    logic                        redirect;
    logic [bpPkg::XLEN-1:0]      redirectPc;

    logic [LINE_W-1:0] goldenMem [MAX_LINES];

    // Global history as seen after each edge
    logic [bpPkg::GHR_BITS-1:0] ghrModel;

    int lineCount;
    int testCount;
    int checkCount;
    int errorCount;
    int testErrors;
    int testLines;
    int cycleCount;
    int timeoutLimit;

    fetchPredictor fetchPredictor_i (
        .clk          (clk),
        .reset        (reset),
        .stallF_i     (stallF),
        .instrF_i     (instrF),
        .resolve_i    (resolve),
        .pcF_o        (pcF),
        .phtIndexF_o  (phtIndexF),
        .redirect_o   (redirect),
        .redirectPc_o (redirectPc)
    );

    always #5 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            $display("Timeout: run did not finish within %0d cycles", timeoutLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic idleInputs();
        stallF  = 1'b0;
        instrF  = 32'h0000_0013;
        resolve = '0;
    endtask

    task automatic applyLine(input goldenLineT g);
        stallF                = g.stall[0];
        instrF                = g.instr;
        resolve.valid         = g.flags[3];
        resolve.isBranch      = g.flags[2];
        resolve.isJump        = g.flags[1];
        resolve.taken         = g.flags[0];
        resolve.pc            = g.pc;
        resolve.target        = g.target;
        resolve.nextPcFetched = g.nextPcFetched;
        resolve.phtIndex      = g.phtIndex[bpPkg::PHT_IDX_W-1:0];
    endtask

    // PC bits 11:2 with the history XOR-ed into the low bits
    function automatic logic [bpPkg::PHT_IDX_W-1:0] foldIndex(
        input logic [31:0]                pc,
        input logic [bpPkg::GHR_BITS-1:0] ghr
    );
        logic [bpPkg::PHT_IDX_W-1:0] idx;

        idx = pc[11:2];
        idx[bpPkg::GHR_BITS-1:0] = idx[bpPkg::GHR_BITS-1:0] ^ ghr;
        return idx;
    endfunction

    task automatic countError();
        errorCount = errorCount + 1;
        testErrors = testErrors + 1;
    endtask

    task automatic checkOutputs(input goldenLineT g, input int lineNum);
        logic [bpPkg::PHT_IDX_W-1:0] expIdx;

        expIdx     = foldIndex(g.expPc, ghrModel);
        checkCount = checkCount + 1;
        if (pcF !== g.expPc) begin
            $display("** Error line %0d: pcF_o expected %h, got %h", lineNum, g.expPc, pcF);
            countError();
        end
        if (redirect !== g.expRedirect[0]) begin
            $display("** Error line %0d: redirect_o expected %h, got %h",
                     lineNum, g.expRedirect[0], redirect);
            countError();
        end
        if (g.expRedirect[0] && (redirectPc !== g.expRedirectPc)) begin
            $display("** Error line %0d: redirectPc_o expected %h, got %h",
                     lineNum, g.expRedirectPc, redirectPc);
            countError();
        end
        if (phtIndexF !== expIdx) begin
            $display("** Error line %0d: phtIndexF_o expected %h, got %h",
                     lineNum, expIdx, phtIndexF);
            countError();
        end
    endtask

    task automatic reportTest(input logic [3:0] testNum, input int lines, input int errors);
        if (errors == 0) begin
            $display("Test %0d: %0d lines, ok", testNum, lines);
        end else begin
            $display("Test %0d: %0d lines, FAILED with %0d errors", testNum, lines, errors);
        end
    endtask

    initial begin
        goldenLineT g;
        logic [3:0] curTest;
        logic       endSeen;

        clk          = 1'b0;
        reset        = 1'b1;
        idleInputs();
        ghrModel     = '0;
        checkCount   = 0;
        errorCount   = 0;
        testErrors   = 0;
        testLines    = 0;
        testCount    = 0;
        cycleCount   = 0;
        endSeen      = 1'b0;
        curTest      = 4'h0;

        for (int i = 0; i < MAX_LINES; i++) begin
            goldenMem[i] = '0;
        end
        $readmemh("test/fetchGolden.txt", goldenMem);

        // A zero test number marks the end of the data
        lineCount = 0;
        for (int i = 0; i < MAX_LINES; i++) begin
            if (goldenMem[i][LINE_W-1 -: 4] == 4'h0) begin
                endSeen = 1'b1;
            end
            if (!endSeen) begin
                lineCount = lineCount + 1;
            end
        end
        timeoutLimit = lineCount + 20 + RESET_CYCLES;

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (lineCount == 0) begin
            $display("No stimulus lines found in test/fetchGolden.txt");
            errorCount = errorCount + 1;
        end else begin
            g         = goldenMem[0];
            curTest   = g.test;
            testCount = 1;
        end

        checkCount = checkCount + 1;
        if (pcF !== bpPkg::PC_START) begin
            $display("** Error after reset: pcF_o expected %h, got %h", bpPkg::PC_START, pcF);
            countError();
        end
        if (redirect !== 1'b0) begin
            $display("** Error after reset: redirect_o expected %h, got %h", 1'b0, redirect);
            countError();
        end
        if (phtIndexF !== foldIndex(bpPkg::PC_START, ghrModel)) begin
            $display("** Error after reset: phtIndexF_o expected %h, got %h",
                     foldIndex(bpPkg::PC_START, ghrModel), phtIndexF);
            countError();
        end

        for (int i = 0; i < lineCount; i++) begin
            g = goldenMem[i];
            if (g.test != curTest) begin
                reportTest(curTest, testLines, testErrors);
                curTest    = g.test;
                testLines  = 0;
                testErrors = 0;
                testCount  = testCount + 1;
            end
            applyLine(g);
            @(posedge clk);
            // Resolved branches shift the history at this edge
            if (g.flags[3] && g.flags[2]) begin
                ghrModel = {ghrModel[bpPkg::GHR_BITS-2:0], g.flags[0]};
            end
            #4;
            checkOutputs(g, i + 1);
            testLines = testLines + 1;
            @(negedge clk);
        end

        if (lineCount > 0) begin
            reportTest(curTest, testLines, testErrors);
        end
        idleInputs();

        $display("Summary: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: test/fetchGolden.txt
// test_stall_instr_flags(valid,isBranch,isJump,taken)_pc_target_nextPcFetched_phtIndex
// _expPcF_expRedirect_expRedirectPc, all hex, one clock cycle per line
// Test 1: cold predictor, PC steps by 4 for any opcode
1_0_00000013_0_00000000_00000000_00000000_000_00001004_0_00000000
1_0_00000063_0_00000000_00000000_00000000_000_00001008_0_00000000
1_0_0000006f_0_00000000_00000000_00000000_000_0000100c_0_00000000
1_0_00000013_0_00000000_00000000_00000000_000_00001010_0_00000000
1_0_00008067_0_00000000_00000000_00000000_000_00001014_0_00000000
// Test 2: stall holds the PC
2_1_00000013_0_00000000_00000000_00000000_000_00001014_0_00000000
2_1_00000013_0_00000000_00000000_00000000_000_00001014_0_00000000
2_1_00000063_0_00000000_00000000_00000000_000_00001014_0_00000000
2_0_00000013_0_00000000_00000000_00000000_000_00001018_0_00000000
// Test 3: first jump resolve redirects through a stall, later fetches predict it
3_1_00000013_b_00001008_00001200_0000100c_000_00001200_1_00001200
3_0_00008067_0_00000000_00000000_00000000_000_00001204_0_00000000
3_0_00000013_b_00001200_00001008_00001204_000_00001008_1_00001008
3_0_0000006f_0_00000000_00000000_00000000_000_00001200_0_00000000
3_0_00008067_0_00000000_00000000_00000000_000_00001008_0_00000000
// Test 4: branch at 1040 trains counter 013, fetched while GHR is 011
4_0_00000013_d_00001040_00001100_00001044_013_00001100_1_00001100
4_0_00000013_d_00001040_00001100_00001100_013_00001104_0_00000000
4_0_00000013_b_00001180_00001040_00001184_000_00001040_1_00001040
4_0_00000063_0_00000000_00000000_00000000_000_00001100_0_00000000
4_0_00000013_c_00001040_00001100_00001044_013_00001104_0_00000000
4_0_00000013_d_00001060_00001300_00001300_01e_00001108_0_00000000
4_0_00000013_d_00001060_00001300_00001300_01d_0000110c_0_00000000
4_0_00000013_b_00001180_00001040_00001184_000_00001040_1_00001040
4_0_00000063_0_00000000_00000000_00000000_000_00001100_0_00000000
// Test 5: taken prediction resolves not taken
5_0_00000013_c_00001040_00001100_00001100_013_00001044_1_00001044
5_0_00000013_0_00000000_00000000_00000000_000_00001048_0_00000000
// Test 6: matching resolves stay quiet, non-branch at a BTB hit steps by 4
6_0_00000013_b_00001180_00001040_00001040_000_0000104c_0_00000000
6_0_00000013_8_00001044_00000000_00001048_000_00001050_0_00000000
6_0_00000013_b_00001180_00001008_00001184_000_00001008_1_00001008
6_0_00000013_0_00000000_00000000_00000000_000_0000100c_0_00000000
6_0_00000013_0_00000000_00000000_00000000_000_00001010_0_00000000

// File: build.f
logic/bpPkg.sv
logic/targetBuffer.sv
logic/directionPredictor.sv
logic/fetchSteer.sv
logic/fetchPredictor.sv
test/fetchPredictorTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the fetch predictor testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=simFetchPredictor
LOG_FILE=sim.log

verilator --binary --timing --assert -f build.f --top-module fetchPredictorTb \
    -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Testbench passed$" "$LOG_FILE"; then
    exit 0
fi
echo "Pass line not found in $LOG_FILE"
exit 1
